// File: design/cart_pkg.sv
// Cartridge type codes, table and address widths, SDRAM placement constants
`default_nettype none

package cart_pkg;

	// ****************************************
	// Supported cartridge types
	// ****************************************

	// Same width as cart_id so the codes compare directly
	typedef enum logic [15:0] {
		cart_generic    = 16'd0,
		cart_ocean      = 16'd5,   // Ocean Type 1
		cart_c64gs      = 16'd15,
		cart_magic_desk = 16'd19,
		cart_easyflash  = 16'd32,
		cart_xbank      = 16'd33   // EasyFlash layout without the Ultimax boot
	} cart_type_e;

	// ****************************************
	// Bank table geometry
	// ****************************************

	localparam int BANK_W     = 7;   // 128 banks of 8K
	localparam int BANK_SLOTS = 64;  // CRT chip packets kept
	localparam int BANK_IDX_W = 6;

	// ****************************************
	// SDRAM layout
	// ****************************************

	localparam int PAGE_W   = 13;  // Offset inside an 8K bank
	localparam int SDRAM_AW = 25;

	// ROM banks live at 0x100000, marker bit sits above the bank number
	localparam logic ROM_BASE_BIT = 1'b1;

	// RAM banks live at 0x010000, only 8 banks reachable
	localparam logic [4:0] RAM_PAGE_BASE = 5'b00001;

	// Chip packet load addresses and sizes
	localparam logic [15:0] LOW_BANK_ADDR = 16'h8000;  // Up to here the packet is ROML
	localparam logic [15:0] BANK_8K       = 16'h2000;  // Anything larger spills into ROMH

endpackage

`default_nettype wire

// File: design/cart_bank_table.sv
// Chip packet bank table with low and high bank slots and a packet counter
`default_nettype none
`timescale 1ns/1ps

module cart_bank_table (
	input  logic                            clk32,
	input  logic                            cart_loading,
	input  logic                            cart_bank_wr,     // One cycle per chip packet
	input  logic [15:0]                     cart_bank_num,
	input  logic [15:0]                     cart_bank_laddr,  // C64 load address of the packet
	input  logic [15:0]                     cart_bank_size,
	input  logic [cart_pkg::SDRAM_AW-1:0]   cart_bank_raddr,  // Where the packet landed in SDRAM
	input  logic [cart_pkg::BANK_IDX_W-1:0] tbl_idx,
	output logic [cart_pkg::BANK_W-1:0]     tbl_lo,
	output logic [cart_pkg::BANK_W-1:0]     tbl_hi,
	output logic [7:0]                      bank_cnt
);

	import cart_pkg::*;

	logic [BANK_W-1:0]     lo_banks [BANK_SLOTS];
	logic [BANK_W-1:0]     hi_banks [BANK_SLOTS];
	logic                  old_loading;
	logic [BANK_W-1:0]     pkt_bank;
	logic [BANK_IDX_W-1:0] pkt_idx;
	logic                  pkt_ok;

	assign pkt_bank = cart_bank_raddr[PAGE_W+BANK_W-1:PAGE_W];  // 8K page number
	assign pkt_idx  = cart_bank_num[BANK_IDX_W-1:0];
	assign pkt_ok   = cart_bank_wr && (cart_bank_num < BANK_SLOTS);  // Drop high bank numbers

	// Packet counter, restarts with every new load
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (cart_loading && !old_loading)
			bank_cnt <= '0;
		if (cart_bank_wr)
			bank_cnt <= bank_cnt + 8'd1;
	end

	// ****************************************
	// Table write
	// ****************************************

	always_ff @(posedge clk32) begin
		if (pkt_ok) begin
			if (cart_bank_laddr <= LOW_BANK_ADDR) begin
				lo_banks[pkt_idx] <= pkt_bank;
				// 16K packet, upper half follows in the next page
				if (cart_bank_size > BANK_8K)
					hi_banks[pkt_idx] <= pkt_bank + BANK_W'(1);
			end else begin
				hi_banks[pkt_idx] <= pkt_bank;  // Loaded at $A000 or $E000
			end
		end
	end

	// Mapper side lookup
	assign tbl_lo = lo_banks[tbl_idx];
	assign tbl_hi = hi_banks[tbl_idx];

endmodule

`default_nettype wire

// File: design/cart_mapper.sv
// Per-type mapper FSM with bank registers, EXROM/GAME overrides and IOF window control
`default_nettype none
`timescale 1ns/1ps

module cart_mapper (
	input  logic                            clk32,
	input  logic                            reset_n,     // Active high, synchronous
	input  logic [15:0]                     cart_id,
	input  logic [7:0]                      cart_exrom,  // EXROM from the CRT header
	input  logic [7:0]                      cart_game,   // GAME from the CRT header
	input  logic                            ioe,
	input  logic                            iof,
	input  logic                            mem_write,
	input  logic [15:0]                     addr_in,
	input  logic [7:0]                      data_in,
	input  logic [cart_pkg::BANK_W-1:0]     tbl_lo,
	input  logic [cart_pkg::BANK_W-1:0]     tbl_hi,
	output logic [cart_pkg::BANK_IDX_W-1:0] tbl_idx,
	output logic                            stb_iof,
	output logic [cart_pkg::BANK_W-1:0]     bank_lo,
	output logic [cart_pkg::BANK_W-1:0]     bank_hi,
	output logic [cart_pkg::BANK_W-1:0]     iof_bank,
	output logic                            iof_ena,
	output logic                            iof_wr_ena,
	output logic                            exrom_ovr,
	output logic                            game_ovr
);

	import cart_pkg::*;

	logic        old_ioe;
	logic        old_iof;
	logic [15:0] old_id;
	logic        init_n;     // Low on the cycle after init
	logic        stb_ioe;
	logic        ioe_wr;
	logic        ioe_rd;
	logic        is_ef;      // EasyFlash or XBank
	cart_type_e  cart_type;

	assign cart_type = cart_type_e'(cart_id);
	assign is_ef     = (cart_type == cart_easyflash) || (cart_type == cart_xbank);

	// ****************************************
	// IO strobes
	// ****************************************

	always_ff @(posedge clk32) begin
		old_ioe <= ioe;
		old_iof <= iof;
		old_id  <= cart_id;  // Type change detect
	end

	assign stb_ioe = ioe & ~old_ioe;  // First cycle of the IO access
	assign stb_iof = iof & ~old_iof;
	assign ioe_wr  = stb_ioe & mem_write;
	assign ioe_rd  = stb_ioe & ~mem_write;

	// EasyFlash bank select reads the table at the written index
	assign tbl_idx = (is_ef && ioe_wr && !addr_in[1]) ? data_in[BANK_IDX_W-1:0] : '0;

	// ****************************************
	// Mapper FSM
	// ****************************************

	always_ff @(posedge clk32) begin
		if (reset_n || (cart_id != old_id)) begin
			init_n     <= 1'b0;
			bank_lo    <= '0;
			bank_hi    <= '0;
			iof_bank   <= '0;
			iof_ena    <= 1'b0;
			iof_wr_ena <= 1'b0;
			exrom_ovr  <= 1'b1;  // Both lines released
			game_ovr   <= 1'b1;
		end else begin
			init_n <= 1'b1;
			case (cart_type)
				// 8K, 16K or Ultimax straight from the header
				cart_generic: begin
					exrom_ovr <= cart_exrom[0];
					game_ovr  <= cart_game[0];
					bank_lo   <= tbl_lo;
					bank_hi   <= tbl_hi;
				end

				// 16K mode, same bank mirrored in both halves
				cart_ocean: begin
					exrom_ovr <= 1'b0;
					game_ovr  <= 1'b0;
					if (ioe_wr) begin
						bank_lo <= BANK_W'(data_in[5:0]);
						bank_hi <= BANK_W'(data_in[5:0]);
					end
				end

				// 8K mode, bank number comes from the address lines
				cart_c64gs: begin
					exrom_ovr <= 1'b0;
					game_ovr  <= 1'b1;
					if (ioe_rd)
						bank_lo <= '0;
					if (ioe_wr)
						bank_lo <= BANK_W'(addr_in[5:0]);
				end

				cart_magic_desk: begin
					if (!init_n) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b1;
						bank_lo   <= '0;
					end
					if (ioe_wr) begin
						bank_lo   <= BANK_W'(data_in[3:0]);
						exrom_ovr <= data_in[7];  // Set bit hides the cartridge
					end
				end

				// Type 32 boots in Ultimax, XBank does not
				cart_easyflash,
				cart_xbank: begin
					if (!init_n) begin
						iof_bank   <= '0;
						iof_ena    <= 1'b1;  // 256 byte RAM at $DF00
						iof_wr_ena <= 1'b1;
						exrom_ovr  <= (cart_type == cart_easyflash);
						game_ovr   <= 1'b0;
						bank_lo    <= tbl_lo;
						bank_hi    <= tbl_hi;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							// $DE02 control, boot jumper assumed at bit 2 = 0
							game_ovr  <= ~data_in[0] & data_in[2];
							exrom_ovr <= ~data_in[1];
						end else begin
							bank_lo <= tbl_lo;  // $DE00 bank
							bank_hi <= tbl_hi;
						end
					end
				end

				default: ;  // Unknown type keeps the init defaults
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/cart_addr_map.sv
// CPU to SDRAM address translation with memory enable and write gating
`default_nettype none
`timescale 1ns/1ps

module cart_addr_map (
	input  logic                          reset_n,
	input  logic                          romL,
	input  logic                          romH,
	input  logic                          umax_romh,   // VIC fetch of ROMH in Ultimax
	input  logic                          ioe,
	input  logic                          iof,
	input  logic                          mem_write,
	input  logic                          mem_ce,
	input  logic                          stb_iof,
	input  logic [15:0]                   addr_in,
	input  logic [cart_pkg::BANK_W-1:0]   bank_lo,
	input  logic [cart_pkg::BANK_W-1:0]   bank_hi,
	input  logic [cart_pkg::BANK_W-1:0]   iof_bank,
	input  logic                          iof_ena,
	input  logic                          iof_wr_ena,
	input  logic                          exrom_ovr,
	input  logic                          game_ovr,
	output logic [cart_pkg::SDRAM_AW-1:0] addr_out,
	output logic                          mem_ce_out,
	output logic                          mem_write_out
);

	import cart_pkg::*;

	logic cs_iof;
	logic rom_rd;

	// ROM page of a bank, 0x100000 and up
	function automatic logic [SDRAM_AW-PAGE_W-1:0] rom_page(input logic [BANK_W-1:0] bank);
		rom_page = {{(SDRAM_AW-PAGE_W-BANK_W-1){1'b0}}, ROM_BASE_BIT, bank};
	endfunction

	// RAM page of a bank, 0x010000 and up
	function automatic logic [SDRAM_AW-PAGE_W-1:0] ram_page(input logic [BANK_W-1:0] bank);
		ram_page = {{(SDRAM_AW-PAGE_W-8){1'b0}}, RAM_PAGE_BASE, bank[2:0]};
	endfunction

	assign cs_iof = iof && (mem_write ? iof_wr_ena : iof_ena);
	assign rom_rd = ~mem_write & ~ioe;  // IOE cycles go to the mapper registers

	assign mem_ce_out = mem_ce | (cs_iof & stb_iof);

	// Ultimax has no RAM under ROML
	assign mem_write_out = ~(romL & exrom_ovr & ~game_ovr) & mem_write;

	// ****************************************
	// Address translation
	// ****************************************

	always_comb begin
		addr_out = {{(SDRAM_AW-16){1'b0}}, addr_in};
		if (!reset_n) begin
			if (romL && rom_rd)
				addr_out[SDRAM_AW-1:PAGE_W] = rom_page(bank_lo);
			if (romH && rom_rd)
				addr_out[SDRAM_AW-1:PAGE_W] = rom_page(bank_hi);

			// $DFxx window
			if (cs_iof)
				addr_out[SDRAM_AW-1:PAGE_W] = iof_wr_ena ? ram_page(iof_bank)
				                                         : rom_page(iof_bank);

			if (umax_romh)
				addr_out[SDRAM_AW-1:PAGE_W-1] = {rom_page(bank_hi), 1'b1};  // Upper 4K
		end
	end

endmodule

`default_nettype wire

// File: design/cartridge.sv
// Cartridge top level with bank table, mapper and address map
`default_nettype none
`timescale 1ns/1ps

module cartridge (
	input  logic                          clk32,
	input  logic                          reset_n,
	input  logic                          cart_loading,
	input  logic [15:0]                   cart_id,
	input  logic [7:0]                    cart_exrom,
	input  logic [7:0]                    cart_game,
	input  logic [15:0]                   cart_bank_num,
	input  logic [15:0]                   cart_bank_laddr,
	input  logic [15:0]                   cart_bank_size,
	input  logic [cart_pkg::SDRAM_AW-1:0] cart_bank_raddr,
	input  logic                          cart_bank_wr,
	input  logic                          romL,
	input  logic                          romH,
	input  logic                          umax_romh,
	input  logic                          ioe,
	input  logic                          iof,
	input  logic                          mem_write,
	input  logic                          mem_ce,
	input  logic [15:0]                   addr_in,
	input  logic [7:0]                    data_in,
	output logic                          exrom,
	output logic                          game,
	output logic [cart_pkg::SDRAM_AW-1:0] addr_out,
	output logic                          mem_ce_out,
	output logic                          mem_write_out,
	output logic [7:0]                    bank_cnt
);

	import cart_pkg::*;

	logic [BANK_IDX_W-1:0] tbl_idx;
	logic [BANK_W-1:0]     tbl_lo;
	logic [BANK_W-1:0]     tbl_hi;
	logic [BANK_W-1:0]     bank_lo;
	logic [BANK_W-1:0]     bank_hi;
	logic [BANK_W-1:0]     iof_bank;
	logic                  iof_ena;
	logic                  iof_wr_ena;
	logic                  stb_iof;
	logic                  exrom_ovr;
	logic                  game_ovr;

	// No forcing logic left, the lines follow the mapper
	assign exrom = exrom_ovr;
	assign game  = game_ovr;

	cart_bank_table u_bank_table (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.tbl_idx         (tbl_idx),
		.tbl_lo          (tbl_lo),
		.tbl_hi          (tbl_hi),
		.bank_cnt        (bank_cnt)
	);

	cart_mapper u_mapper (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.ioe        (ioe),
		.iof        (iof),
		.mem_write  (mem_write),
		.addr_in    (addr_in),
		.data_in    (data_in),
		.tbl_lo     (tbl_lo),
		.tbl_hi     (tbl_hi),
		.tbl_idx    (tbl_idx),
		.stb_iof    (stb_iof),
		.bank_lo    (bank_lo),
		.bank_hi    (bank_hi),
		.iof_bank   (iof_bank),
		.iof_ena    (iof_ena),
		.iof_wr_ena (iof_wr_ena),
		.exrom_ovr  (exrom_ovr),
		.game_ovr   (game_ovr)
	);

	cart_addr_map u_addr_map (
		.reset_n       (reset_n),
		.romL          (romL),
		.romH          (romH),
		.umax_romh     (umax_romh),
		.ioe           (ioe),
		.iof           (iof),
		.mem_write     (mem_write),
		.mem_ce        (mem_ce),
		.stb_iof       (stb_iof),
		.addr_in       (addr_in),
		.bank_lo       (bank_lo),
		.bank_hi       (bank_hi),
		.iof_bank      (iof_bank),
		.iof_ena       (iof_ena),
		.iof_wr_ena    (iof_wr_ena),
		.exrom_ovr     (exrom_ovr),
		.game_ovr      (game_ovr),
		.addr_out      (addr_out),
		.mem_ce_out    (mem_ce_out),
		.mem_write_out (mem_write_out)
	);

endmodule

`default_nettype wire

// File: sim/cartridge_chk.sv
// Mapper checker with assertions on the IOF strobe, reset state and IOF enables, plus its bind
`default_nettype none
`timescale 1ns/1ps

module cartridge_chk (
	input logic clk32,
	input logic reset_n,
	input logic iof,
	input logic stb_iof,
	input logic iof_ena,
	input logic iof_wr_ena
);

	// Strobe marks only the first cycle of an IOF level
	a_stb_single: assert property (@(posedge clk32) stb_iof |-> iof ##1 !stb_iof)
		else $error("stb_iof stayed high for more than one cycle");

	// Window closed while reset is held
	a_reset_iof: assert property (@(posedge clk32) reset_n |=> (!iof_ena && !iof_wr_ena))
		else $error("IOF enables not cleared by reset");

	a_wr_needs_rd: assert property (@(posedge clk32) iof_wr_ena |-> iof_ena)
		else $error("iof_wr_ena set without iof_ena");

endmodule

bind cart_mapper cartridge_chk u_chk (
	.clk32      (clk32),
	.reset_n    (reset_n),
	.iof        (iof),
	.stb_iof    (stb_iof),
	.iof_ena    (iof_ena),
	.iof_wr_ena (iof_wr_ena)
);

`default_nettype wire

// File: sim/cartridge_tb.sv
// Cartridge testbench with clock, packet loading, stimulus, reference model and watchdog
`default_nettype none
`timescale 1ns/1ps

module cartridge_tb;

	import cart_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int N_PKT        = 8;
	localparam int LOAD_CYCLES  = 2 + 2 * N_PKT + 2;
	localparam int CHECK_CYCLES = 20;
	localparam int TEST_CYCLES  = 5 * (RESET_CYCLES + 2 + LOAD_CYCLES + CHECK_CYCLES);

	logic clk32 = 1'b0;
	logic reset_n, cart_loading, cart_bank_wr;
	logic [15:0] cart_id, cart_bank_num, cart_bank_laddr, cart_bank_size;
	logic [SDRAM_AW-1:0] cart_bank_raddr;
	logic [7:0] cart_exrom, cart_game;
	logic romL, romH, umax_romh, ioe, iof, mem_write, mem_ce;
	logic [15:0] addr_in;
	logic [7:0] data_in;
	logic exrom, game, mem_ce_out, mem_write_out;
	logic [SDRAM_AW-1:0] addr_out;
	logic [7:0] bank_cnt;

	// Shadow of the bank table and the mapper state
	logic [BANK_W-1:0] sh_tbl_lo [BANK_SLOTS];
	logic [BANK_W-1:0] sh_tbl_hi [BANK_SLOTS];
	logic [BANK_W-1:0] sh_lo, sh_hi, sh_iof_bank;
	logic sh_iof_ena, sh_iof_wr, sh_exrom, sh_game;
	logic prev_iof;
	logic cmp_en = 1'b0;
	int   err_cnt = 0;

	cartridge u_cartridge (.*);

	always #(CLK_PERIOD / 2) clk32 = ~clk32;

	// ****************************************
	// Reference model and compare
	// ****************************************

	function automatic logic [SDRAM_AW-1:0] expected_addr(
		input logic rst, input logic rl, input logic rh, input logic um,
		input logic io_e, input logic io_f, input logic wr, input logic [15:0] a,
		input logic [BANK_W-1:0] blo, input logic [BANK_W-1:0] bhi,
		input logic [BANK_W-1:0] ibank, input logic iena, input logic iwr);
		logic [SDRAM_AW-1:0] res;
		logic [SDRAM_AW-1:0] off;
		logic rd;
		res = SDRAM_AW'(a);
		off = SDRAM_AW'(a[12:0]);
		rd  = !wr && !io_e;
		if (!rst) begin
			if (rl && rd)
				res = 25'h100000 + SDRAM_AW'(blo) * 25'h2000 + off;
			if (rh && rd)
				res = 25'h100000 + SDRAM_AW'(bhi) * 25'h2000 + off;
			if (io_f && (wr ? iwr : iena)) begin
				if (iwr)
					res = 25'h010000 + SDRAM_AW'(ibank[2:0]) * 25'h2000 + off;  // RAM
				else
					res = 25'h100000 + SDRAM_AW'(ibank) * 25'h2000 + off;
			end
			if (um)  // Upper 4K of the ROMH bank
				res = 25'h100000 + SDRAM_AW'(bhi) * 25'h2000 + 25'h1000 + SDRAM_AW'(a[11:0]);
		end
		return res;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, actual,
				expected);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Outputs are stable half a cycle after the drive
	always @(negedge clk32) begin
		if (cmp_en) begin
			check_eq(32'(addr_out), 32'(expected_addr(reset_n, romL, romH, umax_romh, ioe, iof,
				mem_write, addr_in, sh_lo, sh_hi, sh_iof_bank, sh_iof_ena, sh_iof_wr)),
				"addr_out");
			check_eq(32'(exrom), 32'(sh_exrom), "exrom");
			check_eq(32'(game), 32'(sh_game), "game");
			check_eq(32'(mem_ce_out), 32'(mem_ce | (iof & ~prev_iof &
				(mem_write ? sh_iof_wr : sh_iof_ena))), "mem_ce_out");
			check_eq(32'(mem_write_out), 32'(mem_write & ~(romL & sh_exrom & ~sh_game)),
				"mem_write_out");
		end
	end

	// ****************************************
	// Stimulus helpers
	// ****************************************

	// Next drive point with an idle bus
	task automatic next_cycle();
		@(posedge clk32);
		#5;
		prev_iof  = iof;
		romL      = 1'b0;
		romH      = 1'b0;
		umax_romh = 1'b0;
		ioe       = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
		mem_ce    = 1'b0;
		addr_in   = 16'($urandom);
		data_in   = 8'($urandom);
	endtask

	task automatic set_defaults();
		sh_lo       = '0;
		sh_hi       = '0;
		sh_iof_bank = '0;
		sh_iof_ena  = 1'b0;
		sh_iof_wr   = 1'b0;
		sh_exrom    = 1'b1;
		sh_game     = 1'b1;
	endtask

	task automatic set_powerup(input logic [15:0] id);
		set_defaults();
		case (id)
			cart_generic: begin
				sh_exrom = cart_exrom[0];
				sh_game  = cart_game[0];
				sh_lo    = sh_tbl_lo[0];
				sh_hi    = sh_tbl_hi[0];
			end
			cart_ocean: begin
				sh_exrom = 1'b0;
				sh_game  = 1'b0;
			end
			cart_c64gs, cart_magic_desk: sh_exrom = 1'b0;
			cart_easyflash, cart_xbank: begin
				sh_iof_ena = 1'b1;
				sh_iof_wr  = 1'b1;
				sh_exrom   = (id == cart_easyflash);
				sh_game    = 1'b0;
				sh_lo      = sh_tbl_lo[0];
				sh_hi      = sh_tbl_hi[0];
			end
			default: ;
		endcase
	endtask

	task automatic send_packet(input int idx, input logic [15:0] laddr,
		input logic [15:0] size, input logic [BANK_W-1:0] bank);
		next_cycle();
		cart_loading    = 1'b1;
		cart_bank_wr    = 1'b1;
		cart_bank_num   = 16'(idx);
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_raddr = {5'($urandom), bank, 13'($urandom)};
	endtask

	// Half the entries as 16K packets, the rest as two 8K packets
	task automatic load_table();
		logic [BANK_W-1:0] b;
		int cnt;
		cnt = 0;
		next_cycle();
		cart_loading = 1'b1;
		for (int i = 0; i < N_PKT; i++) begin
			b = BANK_W'($urandom);
			if (i == 0 || ($urandom % 2) == 0) begin
				send_packet(i, 16'h8000, 16'h4000, b);
				sh_tbl_lo[i] = b;
				sh_tbl_hi[i] = b + 7'd1;
				cnt++;
			end else begin
				send_packet(i, 16'h8000, 16'h2000, b);
				sh_tbl_lo[i] = b;
				b = BANK_W'($urandom);
				send_packet(i, 16'hA000, 16'h2000, b);
				sh_tbl_hi[i] = b;
				cnt += 2;
			end
		end
		send_packet(64 + int'($urandom % 100), 16'h8000, 16'h4000, 7'd0);  // Ignored
		cnt++;
		next_cycle();
		cart_bank_wr = 1'b0;
		cart_loading = 1'b0;
		check_eq(32'(bank_cnt), 32'(cnt), "bank_cnt");
	endtask

	task automatic run_reset(input logic [15:0] id);
		next_cycle();
		reset_n = 1'b1;
		cart_id = id;
		next_cycle();  // First reset edge
		set_defaults();
		repeat (RESET_CYCLES - 1) next_cycle();
		reset_n = 1'b0;
		next_cycle();  // Init cycle
		set_powerup(id);
	endtask

	task automatic io_access(input logic wr, input logic [15:0] a, input logic [7:0] d);
		next_cycle();
		ioe       = 1'b1;
		mem_write = wr;
		addr_in   = a;
		data_in   = d;
	endtask

	task automatic rom_reads();
		next_cycle();
		romL   = 1'b1;
		mem_ce = 1'b1;
		next_cycle();
		romH   = 1'b1;
		mem_ce = 1'b1;
	endtask

	task automatic change_type(input logic [15:0] id);
		next_cycle();
		cart_id = id;
		next_cycle();
		set_defaults();
		next_cycle();
		set_powerup(id);
		romL = 1'b1;
	endtask

	// ****************************************
	// Tests
	// ****************************************

	initial begin
		logic [7:0] d;
		logic [15:0] a;
		void'($urandom(69249));
		reset_n = 1'b1;
		cart_id = cart_generic;
		cart_loading = 1'b0;
		cart_bank_wr = 1'b0;
		cart_bank_num = '0;
		cart_bank_laddr = '0;
		cart_bank_size = '0;
		cart_bank_raddr = '0;
		cart_exrom = 8'($urandom);
		cart_game = 8'($urandom);
		{romL, romH, umax_romh, ioe, iof, mem_write, mem_ce} = '0;
		addr_in = '0;
		data_in = '0;
		prev_iof = 1'b0;
		set_defaults();
		next_cycle();
		cmp_en = 1'b1;

		// Generic
		load_table();
		run_reset(cart_generic);
		rom_reads();
		next_cycle();
		umax_romh = 1'b1;

		// Ocean, both banks follow the data
		load_table();
		run_reset(cart_ocean);
		rom_reads();
		d = 8'($urandom);
		io_access(1'b1, 16'hDE00, d);
		next_cycle();
		sh_lo = BANK_W'(d[5:0]);
		sh_hi = BANK_W'(d[5:0]);
		romL = 1'b1;
		next_cycle();
		romH = 1'b1;

		// Magic Desk
		load_table();
		run_reset(cart_magic_desk);
		rom_reads();
		d = 8'($urandom);
		io_access(1'b1, 16'hDE00, d);
		next_cycle();
		sh_lo = BANK_W'(d[3:0]);
		sh_exrom = d[7];
		romL = 1'b1;

		// C64GS, held IOE must not strobe again
		load_table();
		run_reset(cart_c64gs);
		a = 16'hDE00 | 16'($urandom % 64);
		io_access(1'b1, a, 8'($urandom));
		next_cycle();
		sh_lo = BANK_W'(a[5:0]);
		ioe = 1'b1;
		mem_write = 1'b1;
		addr_in = 16'hDE00 | 16'(~a[5:0]);
		next_cycle();
		romL = 1'b1;
		io_access(1'b0, 16'hDE00, 8'h00);
		next_cycle();
		sh_lo = '0;
		romL = 1'b1;

		// EasyFlash
		load_table();
		run_reset(cart_easyflash);
		romL = 1'b1;
		mem_write = 1'b1;  // Ultimax blocks this write
		d = {2'($urandom), 3'b000, 3'($urandom)};
		io_access(1'b1, 16'hDE00, d);
		next_cycle();
		sh_lo = sh_tbl_lo[d[5:0]];
		sh_hi = sh_tbl_hi[d[5:0]];
		rom_reads();
		d = 8'($urandom);
		io_access(1'b1, 16'hDE02, d);
		next_cycle();
		sh_game = ~d[0] & d[2];
		sh_exrom = ~d[1];
		romL = 1'b1;
		next_cycle();
		iof = 1'b1;
		mem_write = 1'($urandom);
		addr_in = 16'hDF00 | 16'($urandom % 256);
		next_cycle();
		iof = 1'b1;  // Held, no second strobe
		addr_in = 16'hDF00 | 16'($urandom % 256);

		// Type changes
		change_type(cart_xbank);
		change_type(cart_generic);
		change_type(cart_ocean);
		change_type(cart_magic_desk);
		change_type(cart_c64gs);
		change_type(cart_easyflash);
		next_cycle();
		cmp_en = 1'b0;

		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog, all tests plus 20 percent
	initial begin
		#(TEST_CYCLES * CLK_PERIOD * 6 / 5);
		$display("Timeout: simulation did not finish in the expected number of cycles");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// File: cartridge.f
design/cart_pkg.sv
design/cart_bank_table.sv
design/cart_mapper.sv
design/cart_addr_map.sv
design/cartridge.sv
sim/cartridge_chk.sv
sim/cartridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cartridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cartridge_tb \
	-f cartridge.f \
	-o Vcartridge_tb

./obj_dir/Vcartridge_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
